// ==== rtl/mmu_pkg.sv ====
package mmu_pkg;

    // Field widths of one joint TLB entry
    localparam int VPN2_W  = 19;
    localparam int ASID_W  = 8;
    localparam int PFN_W   = 20;
    localparam int CACHE_W = 3;

    // Cache attribute that marks a mapped page as uncached
    localparam logic [CACHE_W-1:0] CACHE_UNCACHED = 3'd2;

    // Maintenance operations from the CP0 side
    typedef enum logic [1:0] {
        TU_NOP   = 2'd0,
        TU_TLBWI = 2'd1,    // Write indexed
        TU_TLBR  = 2'd2,    // Read indexed
        TU_TLBP  = 2'd3     // Probe
    } tu_op_e;

    // One entry maps an even/odd pair of 4 KB pages
    typedef struct packed {
        logic [VPN2_W-1:0]  vpn2;
        logic [ASID_W-1:0]  asid;
        logic               g;
        logic [PFN_W-1:0]   pfn0;
        logic [PFN_W-1:0]   pfn1;
        logic [CACHE_W-1:0] c0;
        logic [CACHE_W-1:0] c1;
        logic               d0;
        logic               d1;
        logic               v0;
        logic               v1;
    } tlb_entry_t;

    // Width of one slice in the flattened table
    localparam int ENTRY_W = $bits(tlb_entry_t);

endpackage

// ==== rtl/tlb_lookup.sv ====
`timescale 1ns/1ns

module tlb_lookup #(
    parameter int N_ENTRIES = 16,
    localparam int IDX_W = $clog2(N_ENTRIES)
) (
    input  logic [N_ENTRIES*mmu_pkg::ENTRY_W-1:0] i_table,
    input  logic [31:0]                           i_vaddr,
    input  logic [mmu_pkg::ASID_W-1:0]            i_asid,
    output logic                                  o_hit,
    output logic [IDX_W-1:0]                      o_hit_idx,
    output logic [mmu_pkg::PFN_W-1:0]             o_pfn,
    output logic [mmu_pkg::CACHE_W-1:0]           o_cache,
    output logic                                  o_dirty,
    output logic                                  o_valid
);
    import mmu_pkg::*;

    tlb_entry_t           entries [N_ENTRIES];
    tlb_entry_t           sel;
    logic [N_ENTRIES-1:0] hit_mask;
    logic [IDX_W-1:0]     hit_idx;
    logic                 odd;

    for (genvar i = 0; i < N_ENTRIES; i++) begin : g_match
        assign entries[i] = i_table[i*ENTRY_W +: ENTRY_W];
        // Global entries ignore the ASID
        assign hit_mask[i] = (entries[i].vpn2 == i_vaddr[31:13]) &&
                             ((entries[i].asid == i_asid) || entries[i].g);
    end

    // Lowest matching index wins
    always_comb begin
        hit_idx = '0;
        for (int i = N_ENTRIES - 1; i >= 0; i--) begin
            if (hit_mask[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign sel = entries[hit_idx];
    assign odd = i_vaddr[12];   // Odd page of the pair

    assign o_hit     = |hit_mask;
    assign o_hit_idx = hit_idx;
    assign o_pfn     = odd ? sel.pfn1 : sel.pfn0;
    assign o_cache   = odd ? sel.c1 : sel.c0;
    assign o_dirty   = odd ? sel.d1 : sel.d0;
    assign o_valid   = odd ? sel.v1 : sel.v0;

endmodule

// ==== rtl/addr_xlate.sv ====
`timescale 1ns/1ns

module addr_xlate #(
    parameter int N_ENTRIES = 16,
    parameter bit HAS_WRITE = 1'b1
) (
    input  logic [N_ENTRIES*mmu_pkg::ENTRY_W-1:0] i_table,
    input  logic [31:0]                           i_vaddr,
    input  logic [mmu_pkg::ASID_W-1:0]            i_asid,
    input  logic                                  i_k0_uncached,
    input  logic                                  i_write,
    output logic [31:0]                           o_paddr,
    output logic                                  o_uncached,
    output logic                                  o_refill,
    output logic                                  o_invalid,
    output logic                                  o_modified
);
    import mmu_pkg::*;

    logic               mapped;
    logic               kseg0;
    logic               kseg1;
    logic [31:0]        paddr_direct;
    logic [31:0]        paddr_tlb;
    logic               tlb_hit;
    logic [PFN_W-1:0]   tlb_pfn;
    logic [CACHE_W-1:0] tlb_cache;
    logic               tlb_dirty;
    logic               tlb_valid;

    // kuseg, kseg2 and kseg3 go through the TLB
    assign mapped = !i_vaddr[31] || (i_vaddr[31:30] == 2'b11);
    assign kseg0  = i_vaddr[31:29] == 3'b100;
    assign kseg1  = i_vaddr[31:29] == 3'b101;

    assign paddr_direct = {3'b000, i_vaddr[28:0]};

    tlb_lookup #(
        .N_ENTRIES (N_ENTRIES)
    ) u_lookup (
        .i_table   (i_table),
        .i_vaddr   (i_vaddr),
        .i_asid    (i_asid),
        .o_hit     (tlb_hit),
        .o_hit_idx (),
        .o_pfn     (tlb_pfn),
        .o_cache   (tlb_cache),
        .o_dirty   (tlb_dirty),
        .o_valid   (tlb_valid)
    );

    assign paddr_tlb = {tlb_pfn, i_vaddr[11:0]};
    assign o_paddr   = mapped ? paddr_tlb : paddr_direct;

    always_comb begin
        if (mapped) begin
            o_uncached = tlb_cache == CACHE_UNCACHED;
        end else begin
            o_uncached = kseg1 || (kseg0 && i_k0_uncached);
        end
    end

    assign o_refill  = mapped && !tlb_hit;
    assign o_invalid = mapped && tlb_hit && !tlb_valid;
    // Store to a clean page, data port only
    assign o_modified = HAS_WRITE && mapped && tlb_hit && tlb_valid &&
                        i_write && !tlb_dirty;

    // Flags are mutually exclusive across lookup and segment decode
    always_comb begin
        assert final ($onehot0({o_refill, o_invalid, o_modified}))
            else $error("addr_xlate: more than one exception flag");
    end

endmodule

// ==== rtl/tlb_array.sv ====
`timescale 1ns/1ns

module tlb_array #(
    parameter int N_ENTRIES = 16,
    localparam int IDX_W = $clog2(N_ENTRIES)
) (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  mmu_pkg::tu_op_e                       i_op,
    input  logic [31:0]                           i_op_index,
    input  logic [31:0]                           i_entryhi,
    input  logic [31:0]                           i_entrylo0,
    input  logic [31:0]                           i_entrylo1,
    input  logic                                  i_probe_hit,
    input  logic [IDX_W-1:0]                      i_probe_idx,
    output logic [N_ENTRIES*mmu_pkg::ENTRY_W-1:0] o_table,
    output logic [31:0]                           o_entryhi,
    output logic [31:0]                           o_entrylo0,
    output logic [31:0]                           o_entrylo1,
    output logic [31:0]                           o_index,
    output logic                                  o_op_done
);
    import mmu_pkg::*;

    tlb_entry_t       entries [N_ENTRIES];
    tlb_entry_t       wr_entry;
    tlb_entry_t       rd_entry;
    logic [IDX_W-1:0] op_idx;

    assign op_idx = i_op_index[IDX_W-1:0];

    // Entry from EntryHi and the two EntryLo words
    always_comb begin
        wr_entry      = '0;
        wr_entry.vpn2 = i_entryhi[31:13];
        wr_entry.asid = i_entryhi[7:0];
        wr_entry.g    = i_entrylo0[0] & i_entrylo1[0];
        wr_entry.pfn0 = i_entrylo0[25:6];
        wr_entry.pfn1 = i_entrylo1[25:6];
        wr_entry.c0   = i_entrylo0[5:3];
        wr_entry.c1   = i_entrylo1[5:3];
        wr_entry.d0   = i_entrylo0[2];
        wr_entry.d1   = i_entrylo1[2];
        wr_entry.v0   = i_entrylo0[1];
        wr_entry.v1   = i_entrylo1[1];
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < N_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (i_op == TU_TLBWI) begin
            entries[op_idx] <= wr_entry;
        end
    end

    for (genvar i = 0; i < N_ENTRIES; i++) begin : g_flat
        assign o_table[i*ENTRY_W +: ENTRY_W] = entries[i];
    end

    assign rd_entry = entries[op_idx];

    // Results land one cycle after the op, alongside o_op_done
    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_op_done  <= 1'b0;
            o_entryhi  <= '0;
            o_entrylo0 <= '0;
            o_entrylo1 <= '0;
            o_index    <= '0;
        end else begin
            o_op_done <= i_op != TU_NOP;
            case (i_op)
                TU_TLBR: begin
                    o_entryhi  <= {rd_entry.vpn2, 5'b0, rd_entry.asid};
                    o_entrylo0 <= {6'b0, rd_entry.pfn0, rd_entry.c0,
                                   rd_entry.d0, rd_entry.v0, rd_entry.g};
                    o_entrylo1 <= {6'b0, rd_entry.pfn1, rd_entry.c1,
                                   rd_entry.d1, rd_entry.v1, rd_entry.g};
                end
                TU_TLBP: begin
                    // P bit set on a miss
                    o_index <= {!i_probe_hit, {(31-IDX_W){1'b0}},
                                i_probe_hit ? i_probe_idx : IDX_W'(0)};
                end
                default: ;
            endcase
        end
    end

    a_done_clear_after_reset: assert property (
        @(posedge clk) !resetn |=> !o_op_done
    ) else $error("tlb_array: o_op_done set right after reset");

    a_op_known: assert property (
        @(posedge clk) disable iff (!resetn) !$isunknown(i_op)
    ) else $error("tlb_array: i_op unknown");

endmodule

// ==== rtl/translation_unit.sv ====
`timescale 1ns/1ns

module translation_unit #(
    parameter int N_ENTRIES = 16
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            i_k0_uncached,

    // Fetch port
    input  logic [31:0]     i_if_vaddr,
    output logic [31:0]     o_if_paddr,
    output logic            o_if_uncached,
    output logic            o_if_refill,
    output logic            o_if_invalid,

    // Data port
    input  logic [31:0]     i_dt_vaddr,
    input  logic            i_dt_write,
    output logic [31:0]     o_dt_paddr,
    output logic            o_dt_uncached,
    output logic            o_dt_refill,
    output logic            o_dt_invalid,
    output logic            o_dt_modified,

    // CP0 maintenance
    input  mmu_pkg::tu_op_e i_op,
    input  logic [31:0]     i_op_index,
    input  logic [31:0]     i_entryhi,
    input  logic [31:0]     i_entrylo0,
    input  logic [31:0]     i_entrylo1,
    output logic [31:0]     o_entryhi,
    output logic [31:0]     o_entrylo0,
    output logic [31:0]     o_entrylo1,
    output logic [31:0]     o_index,
    output logic            o_op_done
);
    import mmu_pkg::*;

    localparam int IDX_W = $clog2(N_ENTRIES);

    logic [N_ENTRIES*ENTRY_W-1:0] table_flat;
    logic                         probe_hit;
    logic [IDX_W-1:0]             probe_idx;

    tlb_array #(
        .N_ENTRIES (N_ENTRIES)
    ) u_array (
        .clk         (clk),
        .resetn      (resetn),
        .i_op        (i_op),
        .i_op_index  (i_op_index),
        .i_entryhi   (i_entryhi),
        .i_entrylo0  (i_entrylo0),
        .i_entrylo1  (i_entrylo1),
        .i_probe_hit (probe_hit),
        .i_probe_idx (probe_idx),
        .o_table     (table_flat),
        .o_entryhi   (o_entryhi),
        .o_entrylo0  (o_entrylo0),
        .o_entrylo1  (o_entrylo1),
        .o_index     (o_index),
        .o_op_done   (o_op_done)
    );

    // Fetch never stores
    addr_xlate #(
        .N_ENTRIES (N_ENTRIES),
        .HAS_WRITE (1'b0)
    ) u_if_xlate (
        .i_table       (table_flat),
        .i_vaddr       (i_if_vaddr),
        .i_asid        (i_entryhi[7:0]),
        .i_k0_uncached (i_k0_uncached),
        .i_write       (1'b0),
        .o_paddr       (o_if_paddr),
        .o_uncached    (o_if_uncached),
        .o_refill      (o_if_refill),
        .o_invalid     (o_if_invalid),
        .o_modified    ()
    );

    addr_xlate #(
        .N_ENTRIES (N_ENTRIES),
        .HAS_WRITE (1'b1)
    ) u_dt_xlate (
        .i_table       (table_flat),
        .i_vaddr       (i_dt_vaddr),
        .i_asid        (i_entryhi[7:0]),
        .i_k0_uncached (i_k0_uncached),
        .i_write       (i_dt_write),
        .o_paddr       (o_dt_paddr),
        .o_uncached    (o_dt_uncached),
        .o_refill      (o_dt_refill),
        .o_invalid     (o_dt_invalid),
        .o_modified    (o_dt_modified)
    );

    // Probe matches EntryHi VPN2 and ASID against the table
    tlb_lookup #(
        .N_ENTRIES (N_ENTRIES)
    ) u_probe (
        .i_table   (table_flat),
        .i_vaddr   (i_entryhi),
        .i_asid    (i_entryhi[7:0]),
        .o_hit     (probe_hit),
        .o_hit_idx (probe_idx),
        .o_pfn     (),
        .o_cache   (),
        .o_dirty   (),
        .o_valid   ()
    );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

// ==== tests/tb_checker.sv ====
`timescale 1ns/1ns

module tb_checker #(
    parameter int N_ENTRIES = 16
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic [2:0]      i_test_id,
    input  logic            i_test_end,
    input  logic            i_k0_uncached,
    input  logic [31:0]     i_if_vaddr,
    input  logic [31:0]     i_dt_vaddr,
    input  logic            i_dt_write,
    input  mmu_pkg::tu_op_e i_op,
    input  logic [31:0]     i_op_index,
    input  logic [31:0]     i_entryhi,
    input  logic [31:0]     i_entrylo0,
    input  logic [31:0]     i_entrylo1,
    input  logic [31:0]     i_if_paddr,
    input  logic            i_if_uncached,
    input  logic            i_if_refill,
    input  logic            i_if_invalid,
    input  logic [31:0]     i_dt_paddr,
    input  logic            i_dt_uncached,
    input  logic            i_dt_refill,
    input  logic            i_dt_invalid,
    input  logic            i_dt_modified,
    input  logic [31:0]     i_res_entryhi,
    input  logic [31:0]     i_res_entrylo0,
    input  logic [31:0]     i_res_entrylo1,
    input  logic [31:0]     i_res_index,
    input  logic            i_op_done,
    output int              o_n_pass,
    output int              o_n_fail,
    output int              o_n_checks
);
    import mmu_pkg::*;

    // Reference table, page 0 is even and page 1 is odd
    logic [18:0] m_vpn2 [N_ENTRIES];
    logic [7:0]  m_asid [N_ENTRIES];
    logic        m_g    [N_ENTRIES];
    logic [19:0] m_pfn  [N_ENTRIES][2];
    logic [2:0]  m_c    [N_ENTRIES][2];
    logic        m_d    [N_ENTRIES][2];
    logic        m_v    [N_ENTRIES][2];

    logic        exp_done;
    logic [31:0] exp_ehi;
    logic [31:0] exp_lo0;
    logic [31:0] exp_lo1;
    logic [31:0] exp_index;
    int          test_errs = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          n_checks = 0;

    assign o_n_pass   = n_pass;
    assign o_n_fail   = n_fail;
    assign o_n_checks = n_checks;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0: return "direct";
            3'd1: return "mapped";
            3'd2: return "flags";
            3'd3: return "asid";
            3'd4: return "read";
            default: return "probe";
        endcase
    endfunction

    function automatic logic [31:0] entrylo_word(input logic [19:0] pfn, input logic [2:0] c,
                                                 input logic d, input logic v, input logic g);
        return {6'b0, pfn, c, d, v, g};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        n_checks = n_checks + 1;
        if (act !== exp) begin
            test_errs = test_errs + 1;
            $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // First match in index order
    task automatic find_entry(input logic [31:0] va, input logic [7:0] asid,
                              output logic hit, output int idx);
        hit = 1'b0;
        idx = 0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (!hit && m_vpn2[i] == va[31:13] && (m_asid[i] == asid || m_g[i])) begin
                hit = 1'b1;
                idx = i;
            end
        end
    endtask

    task automatic check_port(input string pfx, input logic has_modf, input logic [31:0] va,
                              input logic wr, input logic [31:0] paddr, input logic unc,
                              input logic refill, input logic inv, input logic modf);
        logic hit;
        int   idx;
        logic pg;
        if (va[31] && va[31:30] != 2'b11) begin
            compare_value({pfx, "paddr"}, {3'b000, va[28:0]}, paddr);
            compare_value({pfx, "uncached"}, 32'((va[31:29] == 3'b101) ||
                          (va[31:29] == 3'b100 && i_k0_uncached)), 32'(unc));
            compare_value({pfx, "refill"}, 32'd0, 32'(refill));
            compare_value({pfx, "invalid"}, 32'd0, 32'(inv));
            if (has_modf) begin
                compare_value({pfx, "modified"}, 32'd0, 32'(modf));
            end
        end else begin
            find_entry(va, i_entryhi[7:0], hit, idx);
            pg = va[12];
            if (hit) begin     // Address is undefined on a refill
                compare_value({pfx, "paddr"}, {m_pfn[idx][pg], va[11:0]}, paddr);
                compare_value({pfx, "uncached"}, 32'(m_c[idx][pg] == CACHE_UNCACHED),
                              32'(unc));
            end
            compare_value({pfx, "refill"}, 32'(!hit), 32'(refill));
            compare_value({pfx, "invalid"}, 32'(hit && !m_v[idx][pg]), 32'(inv));
            if (has_modf) begin
                compare_value({pfx, "modified"},
                              32'(hit && m_v[idx][pg] && wr && !m_d[idx][pg]), 32'(modf));
            end
        end
    endtask

    task automatic apply_op();
        logic hit;
        int   pidx;
        int   idx;
        idx = int'(i_op_index & 32'(N_ENTRIES - 1));
        exp_done = i_op != TU_NOP;
        case (i_op)
            TU_TLBWI: begin
                m_vpn2[idx]   = i_entryhi[31:13];
                m_asid[idx]   = i_entryhi[7:0];
                m_g[idx]      = i_entrylo0[0] & i_entrylo1[0];
                m_pfn[idx][0] = i_entrylo0[25:6];
                m_pfn[idx][1] = i_entrylo1[25:6];
                m_c[idx][0]   = i_entrylo0[5:3];
                m_c[idx][1]   = i_entrylo1[5:3];
                m_d[idx][0]   = i_entrylo0[2];
                m_d[idx][1]   = i_entrylo1[2];
                m_v[idx][0]   = i_entrylo0[1];
                m_v[idx][1]   = i_entrylo1[1];
            end
            TU_TLBR: begin
                exp_ehi = {m_vpn2[idx], 5'b0, m_asid[idx]};
                exp_lo0 = entrylo_word(m_pfn[idx][0], m_c[idx][0], m_d[idx][0],
                                       m_v[idx][0], m_g[idx]);
                exp_lo1 = entrylo_word(m_pfn[idx][1], m_c[idx][1], m_d[idx][1],
                                       m_v[idx][1], m_g[idx]);
            end
            TU_TLBP: begin
                find_entry(i_entryhi, i_entryhi[7:0], hit, pidx);
                exp_index = hit ? 32'(pidx) : 32'h8000_0000;
            end
            default: ;
        endcase
    endtask

    // Inputs change on the rising edge, so the falling edge sees settled outputs
    always @(negedge clk) begin
        if (resetn !== 1'b1) begin
            for (int i = 0; i < N_ENTRIES; i++) begin
                m_vpn2[i] = '0;
                m_asid[i] = '0;
                m_g[i]    = 1'b0;
                for (int j = 0; j < 2; j++) begin
                    m_pfn[i][j] = '0;
                    m_c[i][j]   = '0;
                    m_d[i][j]   = 1'b0;
                    m_v[i][j]   = 1'b0;
                end
            end
            exp_done  = 1'b0;
            exp_ehi   = '0;
            exp_lo0   = '0;
            exp_lo1   = '0;
            exp_index = '0;
        end else begin
            check_port("o_if_", 1'b0, i_if_vaddr, 1'b0, i_if_paddr, i_if_uncached,
                       i_if_refill, i_if_invalid, 1'b0);
            check_port("o_dt_", 1'b1, i_dt_vaddr, i_dt_write, i_dt_paddr, i_dt_uncached,
                       i_dt_refill, i_dt_invalid, i_dt_modified);
            compare_value("o_op_done", 32'(exp_done), 32'(i_op_done));
            compare_value("o_entryhi", exp_ehi, i_res_entryhi);
            compare_value("o_entrylo0", exp_lo0, i_res_entrylo0);
            compare_value("o_entrylo1", exp_lo1, i_res_entrylo1);
            compare_value("o_index", exp_index, i_res_index);
            apply_op();    // Takes effect for the next cycle
            if (i_test_end) begin
                if (test_errs == 0) begin
                    n_pass = n_pass + 1;
                    $display("Test %0d (%s): ok", i_test_id + 1, test_name(i_test_id));
                end else begin
                    n_fail = n_fail + 1;
                    $display("Test %0d (%s): %0d mismatches", i_test_id + 1,
                             test_name(i_test_id), test_errs);
                end
                test_errs = 0;
            end
        end
    end

endmodule

// ==== tests/tb_top.sv ====
`timescale 1ns/1ns

module tb_top;
    import mmu_pkg::*;

    localparam int N_ENTRIES      = 16;
    localparam int N_TESTS        = 6;
    localparam int TEST_CYCLES    = 400;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = N_TESTS * TEST_CYCLES + RESET_CYCLES + 200;

    logic        clk;
    logic        resetn;
    logic        k0_uncached;
    logic [31:0] if_vaddr;
    logic [31:0] dt_vaddr;
    logic        dt_write;
    tu_op_e      op_code;
    logic [31:0] op_index;
    logic [31:0] entryhi;
    logic [31:0] entrylo0;
    logic [31:0] entrylo1;
    logic [31:0] if_paddr;
    logic        if_uncached;
    logic        if_refill;
    logic        if_invalid;
    logic [31:0] dt_paddr;
    logic        dt_uncached;
    logic        dt_refill;
    logic        dt_invalid;
    logic        dt_modified;
    logic [31:0] res_entryhi;
    logic [31:0] res_entrylo0;
    logic [31:0] res_entrylo1;
    logic [31:0] res_index;
    logic        op_done;
    logic [2:0]  test_id;
    logic        test_end;
    int          n_pass;
    int          n_fail;
    int          n_checks;
    int          cycles = 0;
    logic [31:0] rng_state = 32'hee4f;

    tb_clock #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .clk    (clk),
        .resetn (resetn)
    );

    translation_unit #(
        .N_ENTRIES (N_ENTRIES)
    ) u_translation_unit (
        .clk (clk), .resetn (resetn), .i_k0_uncached (k0_uncached),
        .i_if_vaddr (if_vaddr), .o_if_paddr (if_paddr), .o_if_uncached (if_uncached),
        .o_if_refill (if_refill), .o_if_invalid (if_invalid),
        .i_dt_vaddr (dt_vaddr), .i_dt_write (dt_write), .o_dt_paddr (dt_paddr),
        .o_dt_uncached (dt_uncached), .o_dt_refill (dt_refill),
        .o_dt_invalid (dt_invalid), .o_dt_modified (dt_modified),
        .i_op (op_code), .i_op_index (op_index), .i_entryhi (entryhi),
        .i_entrylo0 (entrylo0), .i_entrylo1 (entrylo1), .o_entryhi (res_entryhi),
        .o_entrylo0 (res_entrylo0), .o_entrylo1 (res_entrylo1), .o_index (res_index),
        .o_op_done (op_done)
    );

    tb_checker #(
        .N_ENTRIES (N_ENTRIES)
    ) u_checker (
        .clk (clk), .resetn (resetn), .i_test_id (test_id), .i_test_end (test_end),
        .i_k0_uncached (k0_uncached), .i_if_vaddr (if_vaddr), .i_dt_vaddr (dt_vaddr),
        .i_dt_write (dt_write), .i_op (op_code), .i_op_index (op_index),
        .i_entryhi (entryhi), .i_entrylo0 (entrylo0), .i_entrylo1 (entrylo1),
        .i_if_paddr (if_paddr), .i_if_uncached (if_uncached), .i_if_refill (if_refill),
        .i_if_invalid (if_invalid), .i_dt_paddr (dt_paddr), .i_dt_uncached (dt_uncached),
        .i_dt_refill (dt_refill), .i_dt_invalid (dt_invalid),
        .i_dt_modified (dt_modified), .i_res_entryhi (res_entryhi),
        .i_res_entrylo0 (res_entrylo0), .i_res_entrylo1 (res_entrylo1),
        .i_res_index (res_index), .i_op_done (op_done),
        .o_n_pass (n_pass), .o_n_fail (n_fail), .o_n_checks (n_checks)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic draw(output logic [31:0] r);
        rng_state = xorshift(rng_state);
        r = rng_state;
    endtask

    // Small VPN2 pool so entries collide and match often
    function automatic logic [18:0] pool_vpn2(input logic [1:0] k);
        case (k)
            2'd0: return 19'h00010;
            2'd1: return 19'h12345;
            2'd2: return 19'h60001;    // kseg2
            default: return 19'h7ff00; // kseg3
        endcase
    endfunction

    task automatic drive_cycle(input int t);
        logic [31:0] r [8];
        tu_op_e      op;
        logic [7:0]  asid;
        logic [18:0] vpn2;
        for (int k = 0; k < 8; k++) begin
            draw(r[k]);
        end
        case (t)
            4: op = r[0][0] ? TU_TLBR : (r[0][1] ? TU_TLBWI : TU_NOP);
            5: op = r[0][0] ? TU_TLBP : (r[0][1] ? TU_TLBWI : TU_NOP);
            default: op = (r[0][1:0] == 2'b00) ? TU_TLBWI : TU_NOP;
        endcase
        asid = r[0][2] ? 8'h01 : 8'h02;
        if (t == 3 && op != TU_TLBWI) begin
            asid = 8'h5a;  // No entry owns this ASID
        end else if (t == 5 && r[0][5:3] == 3'd0) begin
            asid = r[0][15:8];
        end
        vpn2 = (t == 5 && r[0][7:6] == 2'b00) ? r[4][31:13] : pool_vpn2(r[0][17:16]);
        if (t == 0) begin
            if_vaddr <= {2'b10, r[1][29:0]};  // kseg0 or kseg1
            dt_vaddr <= {2'b10, r[2][29:0]};
        end else begin
            if_vaddr <= (r[3][1:0] == 2'b00) ? r[1] : {pool_vpn2(r[1][1:0]), r[1][14:2]};
            dt_vaddr <= (r[3][3:2] == 2'b00) ? r[2] : {pool_vpn2(r[2][1:0]), r[2][14:2]};
        end
        dt_write    <= r[3][4];
        k0_uncached <= r[3][5];
        op_code     <= op;
        op_index    <= r[7];
        entryhi     <= {vpn2, r[4][12:8], asid};
        entrylo0    <= r[5];
        entrylo1    <= r[6];
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        k0_uncached = 1'b0;
        if_vaddr    = '0;
        dt_vaddr    = '0;
        dt_write    = 1'b0;
        op_code     = TU_NOP;
        op_index    = '0;
        entryhi     = '0;
        entrylo0    = '0;
        entrylo1    = '0;
        test_id     = '0;
        test_end    = 1'b0;
        @(posedge resetn);
        for (int t = 0; t < N_TESTS; t++) begin
            test_id <= 3'(t);
            repeat (TEST_CYCLES) begin
                @(posedge clk);
                drive_cycle(t);
            end
            @(posedge clk);
            op_code  <= TU_NOP;  // Last op result lands here
            test_end <= 1'b1;
            @(posedge clk);
            test_end <= 1'b0;
        end
        $display("Tests passed: %0d, failed: %0d, checks: %0d", n_pass, n_fail, n_checks);
        if (n_fail == 0 && n_pass == N_TESTS && n_checks > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== mmu.f ====
rtl/mmu_pkg.sv
rtl/tlb_lookup.sv
rtl/addr_xlate.sv
rtl/tlb_array.sv
rtl/translation_unit.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the translation unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f mmu.f --top-module tb_top || exit 1
output="$(./obj_dir/Vtb_top)"
echo "$output"
echo "$output" | grep -qx "test passed" && exit 0 || exit 1
